/* common/mcu_cfg.svh */
////////////////////////////////////////////////////////////
// Build constants for the basic MCU: widths, UART timing,
// loader sync byte and timeout, I/O port addresses
// Included by the RTL and by the testbench
////////////////////////////////////////////////////////////
`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

// Program memory
`define MCU_PC_W 10
`define MCU_PROG_WORDS 1024

// Serial loader
`define MCU_CLKS_PER_BIT 8
`define MCU_SYNC_BYTE 8'd169
`define MCU_PROG_IDLE 400 // Cycles without a byte before programming ends

// I/O space, 6-bit addresses as used by IN and OUT
`define MCU_IO_PORTB 6'd5
`define MCU_IO_PORTD 6'd11

`endif

/* common/mcuPkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the basic MCU core: instruction word
// views, opcode set, status flags and FSM states
////////////////////////////////////////////////////////////
`default_nettype none

package mcuPkg;

	// One program word, seen as immediate or register format
	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [3:0] kHi;
			logic [3:0] dst; // r16..r31
			logic [3:0] kLo;
		} immView;
		struct packed {
			logic [5:0] op6;
			logic srcHi;
			logic [4:0] dst;
			logic [3:0] srcLo;
		} regView;
	} instrWord;

	typedef enum logic [4:0] {
		opNop, opLdi, opSubi, opAndi, opOri,
		opAdd, opSub, opAnd, opOr, opEor, opMov,
		opIn, opOut, opRjmp, opBreq, opBrne,
		opIllegal
	} opcodeT;

	typedef struct packed {
		logic zero;
		logic carry;
		logic negative;
	} flagsT;

	typedef enum logic [2:0] {
		sFetch, sDecode, sExec, sWrite, sHalt
	} coreStateT;

endpackage

`default_nettype wire

/* common/progBusIf.sv */
////////////////////////////////////////////////////////////
// Program memory bus shared by the core and the loader
// fetcher: read requests, writer: word writes
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mcu_cfg.svh"

interface progBusIf;
	logic [`MCU_PC_W-1:0] addr;
	logic [15:0] wrData;
	logic wrEn;
	logic req;
	logic gnt; // Memory port is ours this cycle
	logic [15:0] rdData; // Valid one cycle after a granted request

	modport fetcher
	(
		output req,
		output addr,
		input gnt,
		input rdData
	);

	modport writer
	(
		output addr,
		output wrData,
		output wrEn,
		input gnt
	);
endinterface

`default_nettype wire

/* hw/uartRx.sv */
////////////////////////////////////////////////////////////
// UART receiver, 8N1, LSB first
// Emits one byteValid pulse per good frame at mid stop bit
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mcu_cfg.svh"

module uartRx
(
	input logic clk,
	input logic reseted,
	input logic rxd,
	output logic [7:0] rxByte,
	output logic byteValid
);
	localparam int CntW = $clog2(`MCU_CLKS_PER_BIT);

	logic [1:0] rxSync;
	logic rxBit;
	logic busy;
	logic [3:0] bitCnt; // 0 start, 1..8 data, 9 stop
	logic [CntW-1:0] cycCnt;
	logic sampleNow;

	assign rxBit = rxSync[1];
	assign sampleNow = busy && (cycCnt == '0);

	always_ff @(posedge clk)
	begin
		if (reseted)
		begin
			rxSync <= 2'b11;
			busy <= 1'b0;
			bitCnt <= '0;
			cycCnt <= '0;
			byteValid <= 1'b0;
		end
		else
		begin
			rxSync <= {rxSync[0], rxd};
			byteValid <= 1'b0;
			if (!busy)
			begin
				if (!rxBit) // Falling edge of start bit
				begin
					busy <= 1'b1;
					bitCnt <= '0;
					cycCnt <= CntW'(`MCU_CLKS_PER_BIT / 2 - 1);
				end
			end
			else if (!sampleNow)
				cycCnt <= cycCnt - 1'b1;
			else
			begin
				cycCnt <= CntW'(`MCU_CLKS_PER_BIT - 1);
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == 4'd0)
					busy <= ~rxBit; // Start bit gone high again, treat as a glitch
				else if (bitCnt == 4'd9)
				begin
					busy <= 1'b0;
					byteValid <= rxBit; // Framing error drops the byte
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (sampleNow && bitCnt != 4'd0 && bitCnt != 4'd9)
			rxByte <= {rxBit, rxByte[7:1]};
	end
endmodule

`default_nettype wire

/* loader/progLoader.sv */
////////////////////////////////////////////////////////////
// Serial program loader: sync byte opens programming,
// byte pairs become words written from address 0, and an
// idle timeout closes programming and restarts the core
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mcu_cfg.svh"

module progLoader
(
	input logic clk,
	input logic reseted,
	input logic [7:0] rxByte,
	input logic byteValid,
	output logic progMode,
	output logic coreRestart,
	progBusIf.writer bus
);
	localparam int IdleW = $clog2(`MCU_PROG_IDLE);
	localparam logic [IdleW-1:0] IdleReload = IdleW'(`MCU_PROG_IDLE - 1);

	logic highPhase; // Next byte completes a word
	logic [7:0] lowByte;
	logic [15:0] wordData;
	logic [`MCU_PC_W-1:0] wordAddr;
	logic [IdleW-1:0] idleCnt;
	logic wrStrobe;

	assign bus.addr = wordAddr;
	assign bus.wrData = wordData;
	assign bus.wrEn = wrStrobe & bus.gnt;

	always_ff @(posedge clk)
	begin
		if (reseted)
		begin
			progMode <= 1'b0;
			coreRestart <= 1'b0;
			highPhase <= 1'b0;
			wordAddr <= '0;
			idleCnt <= '0;
			wrStrobe <= 1'b0;
		end
		else
		begin
			coreRestart <= 1'b0;
			wrStrobe <= 1'b0;
			if (wrStrobe)
				wordAddr <= wordAddr + 1'b1; // Advance after each write
			if (!progMode)
			begin
				if (byteValid && rxByte == `MCU_SYNC_BYTE)
				begin
					progMode <= 1'b1;
					highPhase <= 1'b0;
					wordAddr <= '0;
					idleCnt <= IdleReload;
				end
			end
			else if (byteValid)
			begin
				idleCnt <= IdleReload;
				highPhase <= ~highPhase;
				wrStrobe <= highPhase;
			end
			else if (idleCnt == IdleW'(1))
			begin
				// Line went quiet, hand memory back to the core
				progMode <= 1'b0;
				coreRestart <= 1'b1;
			end
			else
				idleCnt <= idleCnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (progMode && byteValid)
		begin
			if (highPhase)
				wordData <= {rxByte, lowByte};
			else
				lowByte <= rxByte; // First byte is the low half
		end
	end
endmodule

`default_nettype wire

/* core/regFile.sv */
////////////////////////////////////////////////////////////
// General purpose registers r0..r31 of the core
// Two combinational reads, one write on the clock edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module regFile
(
	input logic clk,
	input logic [4:0] rdAddrA,
	input logic [4:0] rdAddrB,
	output logic [7:0] rdDataA,
	output logic [7:0] rdDataB,
	input logic [4:0] wrAddr,
	input logic [7:0] wrData,
	input logic wrEn
);
	logic [7:0] regs [32];

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	always_ff @(posedge clk)
	begin
		if (wrEn)
			regs[wrAddr] <= wrData;
	end
endmodule

`default_nettype wire

/* core/avrCore.sv */
////////////////////////////////////////////////////////////
// Small AVR-style core, four granted cycles per instruction
// Fetch, decode, execute, write back. Unknown opcodes halt
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mcu_cfg.svh"

module avrCore
(
	input logic clk,
	input logic reseted,
	input logic coreRestart,
	progBusIf.fetcher bus,
	input logic [7:0] pins,
	output logic [7:0] portB,
	output logic [7:0] portD,
	output logic stuck
);
	mcuPkg::coreStateT state;
	mcuPkg::instrWord instr;
	mcuPkg::opcodeT op;
	mcuPkg::flagsT flags;
	mcuPkg::flagsT newFlags;
	mcuPkg::flagsT flagsNext;
	logic [`MCU_PC_W-1:0] pc;
	logic [`MCU_PC_W-1:0] pcInc;
	logic [`MCU_PC_W-1:0] pcTarget;
	logic [`MCU_PC_W-1:0] pcNext;
	logic signed [11:0] relJump;
	logic signed [6:0] relBranch;
	logic [7:0] regA; // Destination operand
	logic [7:0] regB;
	logic [7:0] kVal;
	logic [7:0] opB;
	logic [7:0] aluRes;
	logic [7:0] resReg;
	logic [8:0] addSum;
	logic [8:0] subDiff; // Borrow in bit 8
	logic [4:0] dstAddr;
	logic [5:0] ioAddr;
	logic isImm;
	logic writesReg;
	logic setsFlags;
	logic setsCarry;
	logic regWrEn;

	function automatic mcuPkg::opcodeT decodeOp(input mcuPkg::instrWord w);
		mcuPkg::opcodeT d;
		d = mcuPkg::opIllegal;
		case (w.immView.op)
			4'b1110: d = mcuPkg::opLdi;
			4'b0101: d = mcuPkg::opSubi;
			4'b0111: d = mcuPkg::opAndi;
			4'b0110: d = mcuPkg::opOri;
			4'b1100: d = mcuPkg::opRjmp;
			4'b1011: d = w.regView.op6[1] ? mcuPkg::opOut : mcuPkg::opIn;
			4'b1111:
			begin
				// Only zero flag branches, bit 0b001 of SREG
				if (!w.regView.op6[1] && w.regView.srcLo[2:0] == 3'b001)
					d = w.regView.op6[0] ? mcuPkg::opBrne : mcuPkg::opBreq;
			end
			default:
			begin
				case (w.regView.op6)
					6'b000000: d = (w == '0) ? mcuPkg::opNop : mcuPkg::opIllegal;
					6'b000011: d = mcuPkg::opAdd;
					6'b000110: d = mcuPkg::opSub;
					6'b001000: d = mcuPkg::opAnd;
					6'b001001: d = mcuPkg::opEor;
					6'b001010: d = mcuPkg::opOr;
					6'b001011: d = mcuPkg::opMov;
					default: d = mcuPkg::opIllegal;
				endcase
			end
		endcase
		return d;
	endfunction

	assign op = decodeOp(instr);
	assign isImm = op inside {mcuPkg::opLdi, mcuPkg::opSubi, mcuPkg::opAndi, mcuPkg::opOri};
	assign writesReg = isImm || op inside {mcuPkg::opAdd, mcuPkg::opSub, mcuPkg::opAnd,
		mcuPkg::opOr, mcuPkg::opEor, mcuPkg::opMov, mcuPkg::opIn};
	assign setsFlags = writesReg && !(op inside {mcuPkg::opLdi, mcuPkg::opMov, mcuPkg::opIn});
	assign setsCarry = op inside {mcuPkg::opAdd, mcuPkg::opSub, mcuPkg::opSubi};

	assign kVal = {instr.immView.kHi, instr.immView.kLo};
	assign dstAddr = isImm ? {1'b1, instr.immView.dst} : instr.regView.dst;
	assign ioAddr = {instr.regView.op6[0], instr.regView.srcHi, instr.regView.srcLo};
	assign opB = isImm ? kVal : regB;
	assign addSum = {1'b0, regA} + {1'b0, opB};
	assign subDiff = {1'b0, regA} - {1'b0, opB};

	always_comb
	begin
		case (op)
			mcuPkg::opLdi: aluRes = kVal;
			mcuPkg::opMov: aluRes = regB;
			mcuPkg::opIn: aluRes = pins;
			mcuPkg::opAdd: aluRes = addSum[7:0];
			mcuPkg::opSub, mcuPkg::opSubi: aluRes = subDiff[7:0];
			mcuPkg::opAnd, mcuPkg::opAndi: aluRes = regA & opB;
			mcuPkg::opOr, mcuPkg::opOri: aluRes = regA | opB;
			mcuPkg::opEor: aluRes = regA ^ opB;
			default: aluRes = regA; // OUT source register
		endcase
	end

	always_comb
	begin
		newFlags = flags;
		if (setsFlags)
		begin
			newFlags.zero = (aluRes == 8'd0);
			newFlags.negative = aluRes[7];
		end
		if (setsCarry)
			newFlags.carry = (op == mcuPkg::opAdd) ? addSum[8] : subDiff[8];
	end

	// Relative targets, offsets count from the next word
	assign relJump = {instr.immView.kHi, instr.immView.dst, instr.immView.kLo};
	assign relBranch = {instr.regView.srcHi, instr.regView.dst, instr.regView.srcLo[3]};
	assign pcInc = pc + 1'b1;

	always_comb
	begin
		case (op)
			mcuPkg::opRjmp: pcTarget = pcInc + `MCU_PC_W'(relJump);
			mcuPkg::opBreq: pcTarget = flags.zero ? pcInc + `MCU_PC_W'(relBranch) : pcInc;
			mcuPkg::opBrne: pcTarget = flags.zero ? pcInc : pcInc + `MCU_PC_W'(relBranch);
			default: pcTarget = pcInc;
		endcase
	end

	assign bus.req = (state != mcuPkg::sHalt);
	assign bus.addr = pc;
	assign stuck = (state == mcuPkg::sHalt);
	assign regWrEn = (state == mcuPkg::sWrite) && bus.gnt && writesReg;

	regFile regs
	(
		.clk(clk),
		.rdAddrA(dstAddr),
		.rdAddrB({instr.regView.srcHi, instr.regView.srcLo}),
		.rdDataA(regA),
		.rdDataB(regB),
		.wrAddr(dstAddr),
		.wrData(resReg),
		.wrEn(regWrEn)
	);

	always_ff @(posedge clk)
	begin
		if (reseted || coreRestart)
		begin
			state <= mcuPkg::sFetch;
			pc <= '0;
			flags <= '0;
			portB <= '0;
			portD <= '0;
		end
		else if (bus.gnt) // No grant, whole core holds
		begin
			case (state)
				mcuPkg::sFetch: state <= mcuPkg::sDecode;
				mcuPkg::sDecode: state <= mcuPkg::sExec;
				mcuPkg::sExec:
					state <= (op == mcuPkg::opIllegal) ? mcuPkg::sHalt : mcuPkg::sWrite;
				mcuPkg::sWrite:
				begin
					state <= mcuPkg::sFetch;
					pc <= pcNext;
					flags <= flagsNext;
					if (op == mcuPkg::opOut && ioAddr == `MCU_IO_PORTB)
						portB <= resReg;
					if (op == mcuPkg::opOut && ioAddr == `MCU_IO_PORTD)
						portD <= resReg;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.gnt && state == mcuPkg::sDecode)
			instr <= bus.rdData; // Word requested in sFetch
		if (bus.gnt && state == mcuPkg::sExec)
		begin
			resReg <= aluRes;
			pcNext <= pcTarget;
			flagsNext <= newFlags;
		end
	end
endmodule

`default_nettype wire

/* hw/sharedProgMem.sv */
////////////////////////////////////////////////////////////
// Single port program memory shared by loader and core
// Loader has fixed priority for the whole programming mode
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mcu_cfg.svh"

module sharedProgMem
(
	input logic clk,
	progBusIf loadBus, // Memory side of the loader's writer bus
	progBusIf fetchBus // Memory side of the core's fetcher bus
);
	logic [15:0] mem [`MCU_PROG_WORDS];
	logic [15:0] rdReg;
	logic [`MCU_PC_W-1:0] portAddr;
	logic writerOwns;

	// Loader claims the port for as long as it programs
	assign writerOwns = loadBus.req;
	assign loadBus.gnt = writerOwns;
	assign fetchBus.gnt = fetchBus.req & ~writerOwns;

	assign portAddr = writerOwns ? loadBus.addr : fetchBus.addr;

	always_ff @(posedge clk)
	begin
		if (writerOwns && loadBus.wrEn)
			mem[portAddr] <= loadBus.wrData;
		else if (fetchBus.gnt)
			rdReg <= mem[portAddr];
	end

	assign fetchBus.rdData = rdReg;
endmodule

`default_nettype wire

/* hw/basicMcu.sv */
////////////////////////////////////////////////////////////
// Top level of the basic MCU: UART loader, shared program
// memory and core, brought out to plain pins
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module basicMcu
(
	input logic clk,
	input logic reseted,
	input logic rxd,
	input logic [7:0] pins,
	output logic [7:0] portB,
	output logic [7:0] portD,
	output logic progMode,
	output logic stuck
);
	logic [7:0] rxByte;
	logic byteValid;
	logic coreRestart;

	progBusIf loadBus();
	progBusIf fetchBus();

	assign loadBus.req = progMode; // Programming mode is the loader's claim

	uartRx rxUnit
	(
		.clk(clk),
		.reseted(reseted),
		.rxd(rxd),
		.rxByte(rxByte),
		.byteValid(byteValid)
	);

	progLoader loader
	(
		.clk(clk),
		.reseted(reseted),
		.rxByte(rxByte),
		.byteValid(byteValid),
		.progMode(progMode),
		.coreRestart(coreRestart),
		.bus(loadBus)
	);

	sharedProgMem progMem
	(
		.clk(clk),
		.loadBus(loadBus),
		.fetchBus(fetchBus)
	);

	avrCore core
	(
		.clk(clk),
		.reseted(reseted),
		.coreRestart(coreRestart),
		.bus(fetchBus),
		.pins(pins),
		.portB(portB),
		.portD(portD),
		.stuck(stuck)
	);
endmodule

`default_nettype wire

/* test/tbBasicMcu.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the basic MCU: programs go in over
// the UART loader, then the output ports are checked
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mcu_cfg.svh"

module tbBasicMcu;
	localparam int OpLdi = 0;
	localparam int OpSubi = 1;
	localparam int OpAndi = 2;
	localparam int OpOri = 3;
	localparam int OpAdd = 4;
	localparam int OpSub = 5;
	localparam int OpAnd = 6;
	localparam int OpOr = 7;
	localparam int OpEor = 8;
	localparam int OpMov = 9;

	localparam logic [5:0] IoPortB = `MCU_IO_PORTB;
	localparam logic [5:0] IoPortD = `MCU_IO_PORTD;
	localparam logic [15:0] RjmpSelf = 16'hCFFF; // Offset -1
	localparam logic [15:0] RjmpBack3 = 16'hCFFD;
	localparam logic [15:0] IllegalWord = 16'h9508; // RET, not in this core

	// Run time budget
	localparam int FrameCycles = 11 * `MCU_CLKS_PER_BIT; // Frame plus one idle bit
	localparam int MaxWords = 12;
	localparam int LoadBound = (2 + 2 * MaxWords) * FrameCycles
		+ `MCU_PROG_IDLE + 8 * `MCU_CLKS_PER_BIT;
	localparam int RunSlack = 8;
	localparam int RunBound = 4 * 56 + RunSlack; // Longest program run
	localparam int NumLoads = 17;
	localparam int NumRuns = 24;
	localparam int WatchdogCycles = 16 + NumLoads * LoadBound + NumRuns * RunBound;

	logic clk;
	logic reseted;
	logic rxd;
	logic [7:0] pins;
	logic [7:0] portB;
	logic [7:0] portD;
	logic progMode;
	logic stuck;

	logic [15:0] progWords[$]; // Program for the next load
	logic [31:0] rngState;
	int errorCount;
	int checkCount;
	int testCount;
	int failedTests;
	int testErrorsAtStart;

	basicMcu i_dut
	(
		.clk(clk),
		.reseted(reseted),
		.rxd(rxd),
		.pins(pins),
		.portB(portB),
		.portD(portD),
		.progMode(progMode),
		.stuck(stuck)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] randomByte();
		rngState = xorshift(rngState);
		return rngState[7:0];
	endfunction

	// AVR encodings, immediate forms work on r16..r31
	function automatic logic [15:0] encodeOp(input int op, input int d, input int r,
		input logic [7:0] k);
		logic [4:0] dd;
		logic [4:0] rr;
		logic [15:0] w;
		dd = d[4:0];
		rr = r[4:0];
		case (op)
			OpLdi: w = {4'b1110, k[7:4], dd[3:0], k[3:0]};
			OpSubi: w = {4'b0101, k[7:4], dd[3:0], k[3:0]};
			OpAndi: w = {4'b0111, k[7:4], dd[3:0], k[3:0]};
			OpOri: w = {4'b0110, k[7:4], dd[3:0], k[3:0]};
			OpAdd: w = {6'b000011, rr[4], dd, rr[3:0]};
			OpSub: w = {6'b000110, rr[4], dd, rr[3:0]};
			OpAnd: w = {6'b001000, rr[4], dd, rr[3:0]};
			OpEor: w = {6'b001001, rr[4], dd, rr[3:0]};
			OpOr: w = {6'b001010, rr[4], dd, rr[3:0]};
			OpMov: w = {6'b001011, rr[4], dd, rr[3:0]};
			default: w = 16'h0000;
		endcase
		return w;
	endfunction

	function automatic logic [15:0] encodeIo(input logic isOut, input logic [5:0] a,
		input logic [4:0] r);
		return {4'b1011, isOut, a[5:4], r, a[3:0]};
	endfunction

	function automatic logic [15:0] encodeBranch(input logic ifNotEqual, input logic [6:0] k);
		return {4'b1111, 1'b0, ifNotEqual, k, 3'b001}; // Tests SREG bit 1, the zero flag
	endfunction

	// 8-bit result of one ALU instruction
	function automatic logic [7:0] modelAlu(input int op, input logic [7:0] x,
		input logic [7:0] y);
		logic [7:0] res;
		case (op)
			OpAdd: res = x + y;
			OpSub, OpSubi: res = x - y;
			OpAnd, OpAndi: res = x & y;
			OpOr, OpOri: res = x | y;
			OpEor: res = x ^ y;
			default: res = y; // LDI and MOV
		endcase
		return res;
	endfunction

	task automatic checkValue(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("failure: %s", what);
	endtask

	task automatic beginTest();
		testErrorsAtStart = errorCount;
		testCount++;
	endtask

	task automatic finishTest(input string name);
		if (errorCount == testErrorsAtStart)
			$display("test %0d %s: ok", testCount, name);
		else
		begin
			failedTests++;
			$display("test %0d %s: %0d errors", testCount, name,
				errorCount - testErrorsAtStart);
		end
	endtask

	task automatic driveBit(input logic value);
		rxd = value;
		repeat (`MCU_CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic sendByte(input logic [7:0] value);
		int i;
		driveBit(1'b0);
		for (i = 0; i < 8; i++)
			driveBit(value[i]);
		driveBit(1'b1);
		driveBit(1'b1); // Idle bit between frames
	endtask

	task automatic runFor(input int instructions);
		repeat (4 * instructions + RunSlack) @(negedge clk);
	endtask

	// Sync byte, words low byte first, then wait out the idle timeout
	task automatic loadProgram();
		logic [7:0] heldB;
		logic [7:0] heldD;
		int waited;
		sendByte(`MCU_SYNC_BYTE);
		checkValue("progMode", 8'(progMode), 8'h01);
		heldB = portB;
		heldD = portD;
		foreach (progWords[i])
		begin
			sendByte(progWords[i][7:0]);
			sendByte(progWords[i][15:8]);
		end
		checkValue("portB", portB, heldB); // Core frozen while programming
		checkValue("portD", portD, heldD);
		waited = 0;
		while (progMode && waited < `MCU_PROG_IDLE + 4 * `MCU_CLKS_PER_BIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (progMode)
			reportFailure("programming mode did not end after the idle timeout");
		else if (waited < `MCU_PROG_IDLE - 4 * `MCU_CLKS_PER_BIT)
			reportFailure($sformatf("programming mode ended early, after %0d cycles", waited));
		@(negedge clk); // Core restart has taken effect
	endtask

	task automatic testLoading();
		logic [7:0] noise;
		logic [7:0] k;
		beginTest();
		checkValue("progMode", 8'(progMode), 8'h00);
		checkValue("stuck", 8'(stuck), 8'h00);
		checkValue("portB", portB, 8'h00);
		checkValue("portD", portD, 8'h00);
		noise = randomByte();
		if (noise == `MCU_SYNC_BYTE)
			noise = noise ^ 8'h01;
		sendByte(noise); // Not the sync byte, must be ignored
		checkValue("progMode", 8'(progMode), 8'h00);
		k = randomByte() | 8'h01;
		progWords.delete();
		progWords.push_back(encodeOp(OpLdi, 16, 0, k));
		progWords.push_back(encodeIo(1'b1, IoPortB, 5'd16));
		progWords.push_back(RjmpSelf);
		loadProgram();
		runFor(2);
		checkValue("portB", portB, k);
		finishTest("loading");
	endtask

	task automatic testAlu();
		int opsA[10] = '{OpAdd, OpSub, OpSubi, OpAnd, OpAndi, OpOr, OpOri, OpEor, OpMov, OpLdi};
		int opsB[6] = '{OpEor, OpAdd, OpSub, OpAnd, OpOr, OpMov};
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] k;
		logic [7:0] resB;
		logic [7:0] resD;
		logic isImm;
		int i;
		beginTest();
		for (i = 0; i < 10; i++)
		begin
			a = randomByte();
			b = randomByte();
			k = randomByte();
			isImm = opsA[i] inside {OpLdi, OpSubi, OpAndi, OpOri};
			resB = modelAlu(opsA[i], a, isImm ? k : b);
			resD = modelAlu(opsB[i % 6], resB, b);
			progWords.delete();
			progWords.push_back(encodeOp(OpLdi, 16, 0, a));
			progWords.push_back(encodeOp(OpLdi, 17, 0, b));
			progWords.push_back(encodeOp(opsA[i], 16, 17, k));
			progWords.push_back(encodeIo(1'b1, IoPortB, 5'd16));
			progWords.push_back(encodeOp(OpMov, 3, 16, 8'h00)); // Low register file half too
			progWords.push_back(encodeOp(opsB[i % 6], 3, 17, 8'h00));
			progWords.push_back(encodeIo(1'b1, IoPortD, 5'd3));
			progWords.push_back(RjmpSelf);
			loadProgram();
			runFor(7);
			checkValue("portB", portB, resB);
			checkValue("portD", portD, resD);
		end
		finishTest("alu");
	endtask

	task automatic testBranches();
		logic [7:0] n;
		logic [7:0] step;
		logic [7:0] x;
		logic [7:0] y;
		int pass;
		beginTest();
		for (pass = 0; pass < 2; pass++)
		begin
			n = (randomByte() % 8'd15) + 8'd1;
			step = randomByte();
			x = randomByte();
			y = (pass == 0) ? x : x ^ (randomByte() | 8'h01);
			progWords.delete();
			progWords.push_back(encodeOp(OpLdi, 16, 0, n));
			progWords.push_back(encodeOp(OpLdi, 17, 0, 8'h00));
			progWords.push_back(encodeOp(OpLdi, 18, 0, step));
			progWords.push_back(encodeOp(OpAdd, 17, 18, 8'h00)); // Loop start
			progWords.push_back(encodeOp(OpSubi, 16, 0, 8'h01));
			progWords.push_back(encodeBranch(1'b1, 7'h7D)); // BRNE back to the ADD
			progWords.push_back(encodeIo(1'b1, IoPortB, 5'd17));
			progWords.push_back(encodeOp(OpLdi, 19, 0, x));
			progWords.push_back(encodeOp(OpSubi, 19, 0, y));
			progWords.push_back(encodeBranch(1'b0, 7'h01)); // BREQ over the next OUT
			progWords.push_back(encodeIo(1'b1, IoPortD, 5'd18));
			progWords.push_back(RjmpSelf);
			loadProgram();
			runFor(3 + 3 * n + 4 + ((x == y) ? 0 : 1));
			checkValue("portB", portB, n * step);
			checkValue("portD", portD, (x == y) ? 8'h00 : step);
		end
		finishTest("branches");
	endtask

	task automatic testInputPort();
		logic [7:0] k;
		int i;
		beginTest();
		k = randomByte() | 8'h01;
		progWords.delete();
		progWords.push_back(encodeOp(OpLdi, 21, 0, k));
		progWords.push_back(encodeIo(1'b1, 6'h3F, 5'd21)); // No port there
		progWords.push_back(encodeIo(1'b0, 6'h10, 5'd5));
		progWords.push_back(encodeIo(1'b1, IoPortD, 5'd5));
		progWords.push_back(RjmpBack3);
		pins = randomByte();
		loadProgram();
		for (i = 0; i < 4; i++)
		begin
			runFor(8); // Two passes of the loop
			checkValue("portD", portD, pins);
			checkValue("portB", portB, 8'h00);
			pins = randomByte();
		end
		finishTest("input port");
	endtask

	task automatic testIllegal();
		logic [7:0] a;
		logic [7:0] b;
		int waited;
		beginTest();
		a = randomByte();
		b = a ^ (randomByte() | 8'h01);
		progWords.delete();
		progWords.push_back(encodeOp(OpLdi, 16, 0, a));
		progWords.push_back(encodeIo(1'b1, IoPortB, 5'd16));
		progWords.push_back(encodeOp(OpLdi, 17, 0, b));
		progWords.push_back(encodeIo(1'b1, IoPortD, 5'd17));
		progWords.push_back(IllegalWord);
		progWords.push_back(encodeIo(1'b1, IoPortB, 5'd17)); // Must never run
		progWords.push_back(RjmpSelf);
		loadProgram();
		waited = 0;
		while (!stuck && waited < 4 * 5 + RunSlack)
		begin
			@(negedge clk);
			waited++;
		end
		if (!stuck)
			reportFailure("core did not halt on an unsupported opcode");
		runFor(4);
		checkValue("stuck", 8'(stuck), 8'h01);
		checkValue("portB", portB, a);
		checkValue("portD", portD, b);
		finishTest("illegal opcode");
	endtask

	task automatic testReload();
		logic [7:0] d;
		logic [7:0] e;
		logic [7:0] f;
		beginTest();
		d = randomByte() | 8'h01;
		e = randomByte() | 8'h01;
		f = randomByte() | 8'h01;
		progWords.delete();
		progWords.push_back(encodeOp(OpLdi, 17, 0, d));
		progWords.push_back(encodeIo(1'b1, IoPortD, 5'd17));
		progWords.push_back(encodeOp(OpLdi, 16, 0, 8'h00));
		progWords.push_back(encodeOp(OpSubi, 16, 0, 8'hFF)); // Counts up forever
		progWords.push_back(encodeIo(1'b1, IoPortB, 5'd16));
		progWords.push_back(RjmpBack3);
		loadProgram();
		checkValue("stuck", 8'(stuck), 8'h00); // Restart leaves the halt state
		runFor(20);
		checkValue("portD", portD, d);
		progWords.delete();
		progWords.push_back(encodeOp(OpLdi, 20, 0, e));
		progWords.push_back(encodeIo(1'b1, IoPortB, 5'd20));
		progWords.push_back(encodeOp(OpLdi, 21, 0, f));
		progWords.push_back(encodeIo(1'b1, IoPortD, 5'd21));
		progWords.push_back(RjmpSelf);
		loadProgram();
		checkValue("portB", portB, 8'h00);
		checkValue("portD", portD, 8'h00);
		runFor(4);
		checkValue("portB", portB, e);
		checkValue("portD", portD, f);
		finishTest("reload");
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stopped", WatchdogCycles);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		reseted = 1'b1;
		rxd = 1'b1; // UART line idles high
		pins = 8'h00;
		rngState = 32'h050b_766d;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		failedTests = 0;
		testErrorsAtStart = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reseted = 1'b0;
		@(negedge clk);
		testLoading();
		testAlu();
		testBranches();
		testInputPort();
		testIllegal();
		testReload();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end
endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/mcuPkg.sv
common/progBusIf.sv
hw/uartRx.sv
loader/progLoader.sv
core/regFile.sv
core/avrCore.sv
hw/sharedProgMem.sv
hw/basicMcu.sv
test/tbBasicMcu.sv

/* run.sh */
#!/bin/sh
# Builds the MCU testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbBasicMcu -f build.f \
	--Mdir obj_dir -o tbBasicMcu
./obj_dir/tbBasicMcu > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
